// File: rtl/stq_pkg.sv
package stq_pkg;

  localparam int addr_w = 20; // word address
  localparam int data_w = 32;
  localparam int be_w   = 4;

  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } size_e;

  typedef enum logic [1:0] {
    st_free      = 2'd0,
    st_addr      = 2'd1, // address in, data pending
    st_ready     = 2'd2,
    st_committed = 2'd3  // waiting for drain
  } entry_st_e;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [1:0]        low;  // byte offset in word
    size_e             size;
  } mem_op_t;

  typedef struct packed {
    logic              hit;
    logic              retry;
    logic [data_w-1:0] data;
  } chk_rsp_t;

  // store on its way out to the cache
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [be_w-1:0]   be;
    logic [data_w-1:0] data;
  } drain_t;

endpackage

// File: rtl/stq_ctrl.sv
`timescale 1ns/1ps

module stq_ctrl import stq_pkg::*; #(
  parameter int depth = 16,
  localparam int iw = $clog2(depth)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wrt_en,
  input  logic [iw-1:0]         wrt_idx,
  input  logic                  upd_en,
  input  logic [iw-1:0]         upd_idx,
  input  logic                  pse_en,
  input  logic                  excpt,
  input  logic                  drain_stall,
  output entry_st_e [depth-1:0] entry_st,
  output logic [iw-1:0]         head,
  output logic                  drain_en,
  output logic                  full
);

  logic [iw-1:0]    cmt;     // next entry to commit
  logic [iw-1:0]    tail;    // next entry to be written
  logic [depth-1:0] data_ok; // data seen, possibly before the address
  logic             drain_go;

  assign drain_en = entry_st[head] == st_committed;
  assign drain_go = drain_en && !drain_stall;
  assign full     = (tail == head) && (entry_st[tail] != st_free);

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      cmt  <= '0;
      tail <= '0;
    end else begin
      if (drain_go) head <= head + 1'b1;
      if (excpt) begin
        tail <= cmt; // everything past the commit point is gone
      end else begin
        if (wrt_en) tail <= wrt_idx + 1'b1;
        if (pse_en) cmt <= cmt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (rst) begin
        entry_st[i] <= st_free;
        data_ok[i]  <= 1'b0;
      end else if (drain_go && head == iw'(i)) begin
        entry_st[i] <= st_free;
        data_ok[i]  <= 1'b0;
      end else if (excpt) begin
        if (entry_st[i] != st_committed) begin
          entry_st[i] <= st_free;
          data_ok[i]  <= 1'b0;
        end
      end else begin
        if (wrt_en && wrt_idx == iw'(i)) begin
          // data may have come first or come right now
          entry_st[i] <= (data_ok[i] || (upd_en && upd_idx == iw'(i))) ? st_ready : st_addr;
        end else if (upd_en && upd_idx == iw'(i) && entry_st[i] == st_addr) begin
          entry_st[i] <= st_ready;
        end else if (pse_en && cmt == iw'(i)) begin
          entry_st[i] <= st_committed;
        end
        if (upd_en && upd_idx == iw'(i)) data_ok[i] <= 1'b1;
      end
    end
  end

  // issue side must hand out only free entries
  assert property (@(posedge clk) disable iff (rst)
    wrt_en && !excpt |-> entry_st[wrt_idx] == st_free);

  // commits come in order and only for stores with data
  assert property (@(posedge clk) disable iff (rst)
    pse_en && !excpt |-> entry_st[cmt] == st_ready);

endmodule

// File: rtl/stq_addr_array.sv
`timescale 1ns/1ps

module stq_addr_array import stq_pkg::*; #(
  parameter int depth = 16,
  localparam int iw = $clog2(depth)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wrt_en,
  input  logic [iw-1:0]     wrt_idx,
  input  mem_op_t           wrt_op,
  input  mem_op_t           chk_op,
  input  logic [iw-1:0]     head,
  output logic [depth-1:0]  overlap,
  output logic [depth-1:0]  covered,
  output logic [addr_w-1:0] head_addr,
  output logic [be_w-1:0]   head_be
);

  logic [addr_w-1:0] addr_q [depth];
  logic [be_w-1:0]   be_q [depth];
  logic [be_w-1:0]   wrt_be;
  logic [be_w-1:0]   chk_be;

  // size and offset to byte lanes
  function automatic logic [be_w-1:0] op_be(input mem_op_t op);
    logic [be_w-1:0] be;
    case (op.size)
      sz_byte: be = 4'b0001 << op.low;
      sz_half: be = 4'b0011 << op.low;
      default: be = 4'b1111;
    endcase
    return be;
  endfunction

  assign wrt_be = op_be(wrt_op);
  assign chk_be = op_be(chk_op);

  always_ff @(posedge clk) begin
    if (wrt_en) begin
      addr_q[wrt_idx] <= wrt_op.addr;
      be_q[wrt_idx]   <= wrt_be;
    end
  end

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      overlap[i] = (addr_q[i] == chk_op.addr) && |(be_q[i] & chk_be);
      covered[i] = (be_q[i] & chk_be) == chk_be; // all load bytes in store
    end
  end

  assign head_addr = addr_q[head];
  assign head_be   = be_q[head];

  // no access may cross the word
  assert property (@(posedge clk) disable iff (rst)
    wrt_en |-> (wrt_op.size != sz_half || !wrt_op.low[0]) &&
               (wrt_op.size != sz_word || wrt_op.low == 2'd0));

endmodule

// File: rtl/stq_age_pick.sv
`timescale 1ns/1ps

module stq_age_pick import stq_pkg::*; #(
  parameter int depth = 16,
  localparam int iw = $clog2(depth)
) (
  input  entry_st_e [depth-1:0] entry_st,
  input  logic [iw-1:0]         head,
  input  logic [iw-1:0]         chk_wq,
  input  logic [depth-1:0]      overlap,
  input  logic [depth-1:0]      covered,
  output logic [depth-1:0]      sel,
  output logic                  partial
);

  logic [depth-1:0] cand;
  logic [iw-1:0]    span; // distance from head to the load
  logic [iw-1:0]    idx;
  logic             found;

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      cand[i] = overlap[i] && (entry_st[i] != st_free);
    end
  end

  assign span = chk_wq - head;

  // walk backwards from chk_wq, stop at head
  always_comb begin
    sel   = '0;
    found = 1'b0;
    idx   = chk_wq;
    for (int k = 0; k < depth; k++) begin
      idx = chk_wq - iw'(k);
      if (!found && iw'(k) <= span && cand[idx]) begin
        sel[idx] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  assign partial = |(sel & ~covered);

endmodule

// File: rtl/stq_data_array.sv
`timescale 1ns/1ps

module stq_data_array import stq_pkg::*; #(
  parameter int depth = 16,
  localparam int iw = $clog2(depth)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  upd_en,
  input  logic [iw-1:0]         upd_idx,
  input  logic [data_w-1:0]     upd_data,
  input  logic                  chk_en,
  input  logic [depth-1:0]      sel,
  input  logic                  partial,
  input  entry_st_e [depth-1:0] entry_st,
  input  logic [iw-1:0]         head,
  output logic                  chk_rsp_en,
  output chk_rsp_t              chk_rsp,
  output logic [data_w-1:0]     head_data
);

  logic [data_w-1:0] data_q [depth];
  logic [data_w-1:0] sel_data;
  logic              sel_rdy; // selected store has its data
  logic              hit;

  always_ff @(posedge clk) begin
    if (upd_en) data_q[upd_idx] <= upd_data;
  end

  // one-hot mux
  always_comb begin
    sel_data = '0;
    sel_rdy  = 1'b0;
    for (int i = 0; i < depth; i++) begin
      if (sel[i]) begin
        sel_data = sel_data | data_q[i];
        sel_rdy  = sel_rdy | (entry_st[i] inside {st_ready, st_committed});
      end
    end
  end

  assign hit = sel_rdy && !partial;

  always_ff @(posedge clk) begin
    if (rst) chk_rsp_en <= 1'b0;
    else chk_rsp_en <= chk_en;
  end

  always_ff @(posedge clk) begin
    if (chk_en) begin
      chk_rsp <= '{hit: hit, retry: (|sel) && !hit, data: hit ? sel_data : '0};
    end
  end

  assign head_data = data_q[head];

endmodule

// File: rtl/stq_top.sv
`timescale 1ns/1ps

module stq_top import stq_pkg::*; #(
  parameter int depth = 16,
  localparam int iw = $clog2(depth)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wrt_en,
  input  logic [iw-1:0]     wrt_idx,
  input  mem_op_t           wrt_op,
  input  logic              upd_en,
  input  logic [iw-1:0]     upd_idx,
  input  logic [data_w-1:0] upd_data,
  input  logic              pse_en,
  input  logic              chk_en,
  input  logic [iw-1:0]     chk_wq,
  input  mem_op_t           chk_op,
  input  logic              drain_stall,
  input  logic              excpt,
  output logic              chk_rsp_en,
  output chk_rsp_t          chk_rsp,
  output logic              drain_en,
  output drain_t            drain,
  output logic              full
);

  entry_st_e [depth-1:0] entry_st;
  logic [iw-1:0]         head;
  logic [depth-1:0]      overlap;
  logic [depth-1:0]      covered;
  logic [depth-1:0]      sel;
  logic                  partial;
  logic [addr_w-1:0]     head_addr;
  logic [be_w-1:0]       head_be;
  logic [data_w-1:0]     head_data;

  assign drain = '{addr: head_addr, be: head_be, data: head_data};

  stq_ctrl #(.depth(depth)) ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .wrt_en      (wrt_en),
    .wrt_idx     (wrt_idx),
    .upd_en      (upd_en),
    .upd_idx     (upd_idx),
    .pse_en      (pse_en),
    .excpt       (excpt),
    .drain_stall (drain_stall),
    .entry_st    (entry_st),
    .head        (head),
    .drain_en    (drain_en),
    .full        (full)
  );

  stq_addr_array #(.depth(depth)) addr_i (
    .clk       (clk),
    .rst       (rst),
    .wrt_en    (wrt_en),
    .wrt_idx   (wrt_idx),
    .wrt_op    (wrt_op),
    .chk_op    (chk_op),
    .head      (head),
    .overlap   (overlap),
    .covered   (covered),
    .head_addr (head_addr),
    .head_be   (head_be)
  );

  stq_age_pick #(.depth(depth)) pick_i (
    .entry_st (entry_st),
    .head     (head),
    .chk_wq   (chk_wq),
    .overlap  (overlap),
    .covered  (covered),
    .sel      (sel),
    .partial  (partial)
  );

  stq_data_array #(.depth(depth)) data_i (
    .clk        (clk),
    .rst        (rst),
    .upd_en     (upd_en),
    .upd_idx    (upd_idx),
    .upd_data   (upd_data),
    .chk_en     (chk_en),
    .sel        (sel),
    .partial    (partial),
    .entry_st   (entry_st),
    .head       (head),
    .chk_rsp_en (chk_rsp_en),
    .chk_rsp    (chk_rsp),
    .head_data  (head_data)
  );

endmodule

// File: tests/stq_tb.sv
`timescale 1ns/1ps

module stq_tb import stq_pkg::*; ();

  localparam int depth = 16;
  localparam int dir_cycles = 200;  // directed part, with margin
  localparam int rnd_cycles = 2000; // cap on the random loop

  logic clk = 1'b0;
  logic rst, wrt_en, upd_en, pse_en, chk_en, drain_stall, excpt;
  logic [3:0] wrt_idx, upd_idx, chk_wq;
  logic [31:0] upd_data;
  mem_op_t wrt_op, chk_op;
  logic chk_rsp_en, drain_en, full;
  chk_rsp_t chk_rsp;
  drain_t drain;
  int errors = 0;
  int seed = 59;
  logic [3:0] alloc = '0; // next entry handed out by the issue side
  logic saw_full = 1'b0;
  logic saw_wrap = 1'b0;

  // reference model
  entry_st_e m_st [depth];
  logic [19:0] m_addr [depth];
  logic [3:0] m_be [depth];
  logic [31:0] m_data [depth];
  logic m_dok [depth];
  logic [3:0] m_head, m_cmt, m_tail;
  logic exp_rsp_en;
  chk_rsp_t exp_rsp;
  logic exp_drain_en, exp_full, drain_go;
  drain_t exp_drain;

  stq_top #(.depth(depth)) stq_top_i (.*);

  always #50 clk = ~clk;

  function automatic logic [3:0] lanes(input mem_op_t op);
    if (op.size == sz_word) return 4'hf;
    if (op.size == sz_half) return 4'h3 << op.low;
    return 4'h1 << op.low;
  endfunction

  // youngest overlapping store from chk_wq back to head
  function automatic chk_rsp_t expect_check(input logic [3:0] wq, input mem_op_t op);
    chk_rsp_t r;
    logic [3:0] idx;
    logic [3:0] span;
    logic [3:0] ld;
    r = '0;
    ld = lanes(op);
    span = wq - m_head;
    for (int k = 0; k <= int'(span); k++) begin
      idx = wq - 4'(k);
      if (m_st[idx] != st_free && m_addr[idx] == op.addr && |(m_be[idx] & ld)) begin
        r.hit = ((m_be[idx] & ld) == ld) && (m_st[idx] inside {st_ready, st_committed});
        r.retry = !r.hit;
        r.data = r.hit ? m_data[idx] : '0;
        return r;
      end
    end
    return r;
  endfunction

  assign exp_drain_en = m_st[m_head] == st_committed;
  assign exp_drain = '{addr: m_addr[m_head], be: m_be[m_head], data: m_data[m_head]};
  assign exp_full = m_st[m_tail] != st_free;
  assign drain_go = exp_drain_en && !drain_stall;

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        m_st[i] <= st_free;
        m_dok[i] <= 1'b0;
      end
      m_head <= '0;
      m_cmt <= '0;
      m_tail <= '0;
      exp_rsp_en <= 1'b0;
    end else begin
      exp_rsp_en <= chk_en;
      if (chk_en) exp_rsp <= expect_check(chk_wq, chk_op);
      if (drain_go) m_head <= m_head + 1'b1;
      if (excpt) begin
        m_tail <= m_cmt;
      end else begin
        if (wrt_en) begin
          m_tail <= wrt_idx + 1'b1;
          m_addr[wrt_idx] <= wrt_op.addr;
          m_be[wrt_idx] <= lanes(wrt_op);
        end
        if (upd_en) m_data[upd_idx] <= upd_data;
        if (pse_en) m_cmt <= m_cmt + 1'b1;
      end
      for (int i = 0; i < depth; i++) begin
        if ((drain_go && m_head == 4'(i)) || (excpt && m_st[i] != st_committed)) begin
          m_st[i] <= st_free;
          m_dok[i] <= 1'b0;
        end else if (!excpt) begin
          if (wrt_en && wrt_idx == 4'(i))
            m_st[i] <= (m_dok[i] || (upd_en && upd_idx == 4'(i))) ? st_ready : st_addr;
          else if (upd_en && upd_idx == 4'(i) && m_st[i] == st_addr) m_st[i] <= st_ready;
          else if (pse_en && m_cmt == 4'(i)) m_st[i] <= st_committed;
          if (upd_en && upd_idx == 4'(i)) m_dok[i] <= 1'b1;
        end
      end
    end
  end

  task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    errors++;
  endtask

  a_rsp_en: assert property (@(posedge clk) disable iff (rst) chk_rsp_en == exp_rsp_en)
    else mismatch("chk_rsp_en", 64'($sampled(exp_rsp_en)), 64'($sampled(chk_rsp_en)));
  a_hit: assert property (@(posedge clk) disable iff (rst) chk_rsp_en |-> chk_rsp.hit == exp_rsp.hit)
    else mismatch("chk_rsp.hit", 64'($sampled(exp_rsp.hit)), 64'($sampled(chk_rsp.hit)));
  a_retry: assert property (@(posedge clk) disable iff (rst)
    chk_rsp_en |-> chk_rsp.retry == exp_rsp.retry)
    else mismatch("chk_rsp.retry", 64'($sampled(exp_rsp.retry)), 64'($sampled(chk_rsp.retry)));
  a_data: assert property (@(posedge clk) disable iff (rst)
    chk_rsp_en && exp_rsp.hit |-> chk_rsp.data == exp_rsp.data)
    else mismatch("chk_rsp.data", 64'($sampled(exp_rsp.data)), 64'($sampled(chk_rsp.data)));
  a_drain_en: assert property (@(posedge clk) disable iff (rst) drain_en == exp_drain_en)
    else mismatch("drain_en", 64'($sampled(exp_drain_en)), 64'($sampled(drain_en)));
  a_drain: assert property (@(posedge clk) disable iff (rst) drain_en |-> drain == exp_drain)
    else mismatch("drain", 64'($sampled(exp_drain)), 64'($sampled(drain)));
  a_full: assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else mismatch("full", 64'($sampled(exp_full)), 64'($sampled(full)));

  function automatic int rnd(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic mem_op_t rand_op();
    mem_op_t op;
    op.addr = 20'(rnd(3)); // few addresses, many overlaps
    op.size = size_e'(2'(rnd(3)));
    op.low = (op.size == sz_byte) ? 2'(rnd(4)) : (op.size == sz_half) ? 2'(2 * rnd(2)) : 2'd0;
    return op;
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    wrt_en = 1'b0;
    upd_en = 1'b0;
    pse_en = 1'b0;
    chk_en = 1'b0;
    excpt = 1'b0;
  endtask

  task automatic put_addr(input logic [19:0] a, input logic [1:0] low, input size_e sz);
    next_cycle();
    wrt_en = 1'b1;
    wrt_idx = alloc;
    wrt_op = '{addr: a, low: low, size: sz};
    alloc = alloc + 1'b1;
  endtask

  task automatic put_data(input logic [3:0] idx, input logic [31:0] d);
    next_cycle();
    upd_en = 1'b1;
    upd_idx = idx;
    upd_data = d;
  endtask

  task automatic load(input logic [3:0] wq, input logic [19:0] a, input logic [1:0] low,
                      input size_e sz);
    next_cycle();
    chk_en = 1'b1;
    chk_wq = wq;
    chk_op = '{addr: a, low: low, size: sz};
  endtask

  task automatic commit();
    next_cycle();
    pse_en = 1'b1;
  endtask

  task automatic flush();
    next_cycle();
    excpt = 1'b1;
    alloc = m_cmt;
  endtask

  task automatic wait_drained();
    while (m_head != alloc) next_cycle();
  endtask

  initial begin
    #(2 * (dir_cycles + rnd_cycles) * 100);
    $display("watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    {wrt_en, upd_en, pse_en, chk_en, drain_stall, excpt} = '0;
    {wrt_idx, upd_idx, chk_wq, upd_data} = '0;
    wrt_op = '0;
    chk_op = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    load(4'd0, 20'h5, 2'd0, sz_word); // empty queue
    put_addr(20'h100, 2'd0, sz_word);
    put_data(4'd0, 32'h11223344);
    put_addr(20'h100, 2'd0, sz_word);
    put_data(4'd1, 32'haabbccdd);
    load(4'd1, 20'h100, 2'd1, sz_byte); // nearer store wins
    load(4'd0, 20'h100, 2'd2, sz_half);
    put_addr(20'h200, 2'd0, sz_byte);
    put_data(4'd2, 32'h000000ee);
    load(4'd2, 20'h200, 2'd0, sz_word); // partial
    put_addr(20'h300, 2'd0, sz_word);
    load(4'd3, 20'h300, 2'd3, sz_byte); // no data yet
    load(4'd2, 20'h300, 2'd0, sz_word); // store is younger
    put_data(4'd3, 32'h55667788);
    drain_stall = 1'b1;
    repeat (4) commit();
    repeat (4) next_cycle();
    drain_stall = 1'b0;
    repeat (2) next_cycle();
    drain_stall = 1'b1;
    repeat (2) next_cycle();
    drain_stall = 1'b0;
    wait_drained();
    put_addr(20'h400, 2'd0, sz_word);
    put_data(4'd4, 32'h0badcafe);
    put_data(4'd6, 32'h12345678); // data ahead of its address
    put_addr(20'h400, 2'd2, sz_half);
    put_addr(20'h600, 2'd0, sz_word);
    drain_stall = 1'b1;
    commit();
    flush();
    load(4'd6, 20'h400, 2'd2, sz_half);
    load(4'd6, 20'h600, 2'd0, sz_word);
    drain_stall = 1'b0;
    wait_drained();

    for (int n = 0; n < rnd_cycles && !(saw_full && saw_wrap && n > 300); n++) begin
      logic [3:0] pick;
      logic [3:0] base;
      next_cycle();
      // long stall phases let the queue fill up
      drain_stall = ((n / 40) % 2 == 1) ? (rnd(5) != 0) : (rnd(5) == 0);
      if (exp_full) saw_full = 1'b1;
      if (rnd(60) == 0) begin
        excpt = 1'b1;
        alloc = m_cmt;
        continue;
      end
      base = alloc;
      if (m_st[alloc] == st_free && rnd(10) < 7) begin
        wrt_en = 1'b1;
        wrt_idx = alloc;
        wrt_op = rand_op();
        alloc = alloc + 1'b1;
        if (alloc == 4'd0) saw_wrap = 1'b1;
      end
      pick = 4'(rnd(depth));
      if ((m_st[pick] == st_addr || (pick == base && m_st[pick] == st_free)) && rnd(10) < 8) begin
        upd_en = 1'b1;
        upd_idx = pick;
        upd_data = $random(seed);
      end
      if (m_st[m_cmt] == st_ready && rnd(10) < 6) pse_en = 1'b1;
      if (rnd(2) == 0) begin
        chk_en = 1'b1;
        chk_wq = 4'(rnd(depth));
        chk_op = rand_op();
      end
    end
    if (!saw_full || !saw_wrap) begin
      $display("random mix ended without reaching both full and wrap-around");
      errors++;
    end
    drain_stall = 1'b0;
    repeat (20) next_cycle();
    $display("checks failed: %0d", errors);
    if (errors == 0) $display(">>> PASS");
    else $display(">>> FAIL");
    $finish;
  end

endmodule

// File: flist.f
rtl/stq_pkg.sv
rtl/stq_ctrl.sv
rtl/stq_addr_array.sv
rtl/stq_age_pick.sv
rtl/stq_data_array.sv
rtl/stq_top.sv
tests/stq_tb.sv

// File: Makefile
TOP = stq_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q ">>> FAIL" sim.log
	@grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log
